// File: hdl/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // buffer geometry
    localparam int unsigned rob_depth = 16;
    localparam int unsigned nick_w    = 4;
    localparam int unsigned count_w   = 5;

    // architectural widths
    localparam int unsigned regnm_w = 5;
    localparam int unsigned data_w  = 32;
    localparam int unsigned addr_w  = 32;

    // tag of one buffer entry
    typedef logic [nick_w-1:0]  nick_t;
    typedef logic [regnm_w-1:0] regnm_t;
    typedef logic [data_w-1:0]  data_t;
    typedef logic [addr_w-1:0]  addr_t;

    // 0 to rob_depth, so one bit wider than the tag
    typedef logic [count_w-1:0] count_t;

    // one flush cycle after a mispredicted branch commits
    typedef enum logic {
        run,
        flush
    } commit_state_t;

endpackage

`default_nettype wire

// File: hdl/rob_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module rob_alloc (
    input  logic            clk,
    input  logic            arst_n,

    input  logic            alloc_en,
    input  logic            alloc_store,
    input  logic            alloc_pred,
    input  rob_pkg::regnm_t alloc_regnm,

    input  logic            retire,
    input  logic            flush_all,
    input  rob_pkg::nick_t  head_nick,

    output logic            full,
    output logic            nick_valid,
    output rob_pkg::nick_t  nick,
    output logic            occupied,

    output rob_pkg::regnm_t head_regnm,
    output logic            head_store,
    output logic            head_pred
);

    rob_pkg::nick_t  wr_ptr;
    rob_pkg::count_t count;

    // rename half of each entry
    rob_pkg::regnm_t regnm_q [rob_pkg::rob_depth];
    logic            store_q [rob_pkg::rob_depth];
    logic            pred_q  [rob_pkg::rob_depth];

    assign full       = (count == rob_pkg::count_t'(rob_pkg::rob_depth));
    assign occupied   = (count != '0);
    assign nick_valid = alloc_en && !full;
    assign nick       = wr_ptr;

    // pointer and occupancy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush_all) begin
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (nick_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // alloc and retire together leave the count unchanged
            case ({nick_valid, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (nick_valid) begin
            regnm_q[wr_ptr] <= alloc_regnm;
            store_q[wr_ptr] <= alloc_store;
            pred_q[wr_ptr]  <= alloc_pred;
        end
    end

    // head record for commit
    assign head_regnm = regnm_q[head_nick];
    assign head_store = store_q[head_nick];
    assign head_pred  = pred_q[head_nick];

endmodule

`default_nettype wire

// File: hdl/rob_result.sv
`timescale 1ns/1ps
`default_nettype none

module rob_result (
    input  logic            clk,
    input  logic            arst_n,

    input  logic            ex_en,
    input  rob_pkg::nick_t  ex_nick,
    input  rob_pkg::data_t  ex_data,
    input  logic            ex_taken,
    input  rob_pkg::addr_t  ex_target,

    input  logic            slb_en,
    input  rob_pkg::nick_t  slb_nick,
    input  rob_pkg::data_t  slb_data,

    input  logic            retire,
    input  logic            flush_all,
    input  rob_pkg::nick_t  head_nick,

    output logic            head_done,
    output rob_pkg::data_t  head_data,
    output logic            head_taken,
    output rob_pkg::addr_t  head_target
);

    logic [rob_pkg::rob_depth-1:0] done;

    rob_pkg::data_t data_q   [rob_pkg::rob_depth];
    logic           taken_q  [rob_pkg::rob_depth];
    rob_pkg::addr_t target_q [rob_pkg::rob_depth];

    // done bits, set by either completion source
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= '0;
        end else if (flush_all) begin
            done <= '0;
        end else begin
            if (retire) begin
                done[head_nick] <= 1'b0;
            end
            if (ex_en) begin
                done[ex_nick] <= 1'b1;
            end
            if (slb_en) begin
                done[slb_nick] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_en) begin
            data_q[ex_nick]   <= ex_data;
            taken_q[ex_nick]  <= ex_taken;
            target_q[ex_nick] <= ex_target;
        end
        // memory ops never branch
        if (slb_en) begin
            data_q[slb_nick]  <= slb_data;
            taken_q[slb_nick] <= 1'b0;
        end
    end

    assign head_done   = done[head_nick];
    assign head_data   = data_q[head_nick];
    assign head_taken  = taken_q[head_nick];
    assign head_target = target_q[head_nick];

endmodule

`default_nettype wire

// File: hdl/rob_commit.sv
`timescale 1ns/1ps
`default_nettype none

module rob_commit (
    input  logic            clk,
    input  logic            arst_n,

    input  rob_pkg::regnm_t head_regnm,
    input  logic            head_store,
    input  logic            head_pred,
    input  logic            head_done,
    input  logic            head_taken,
    input  rob_pkg::data_t  head_data,
    input  rob_pkg::addr_t  head_target,
    input  logic            occupied,

    output rob_pkg::nick_t  head_nick,
    output logic            retire,
    output logic            flush_all,

    output logic            rf_en,
    output rob_pkg::regnm_t rf_regnm,
    output rob_pkg::data_t  rf_data,
    output rob_pkg::nick_t  rf_nick,

    output logic            store_en,
    output rob_pkg::nick_t  store_nick,

    output logic            flush,
    output rob_pkg::addr_t  redirect_pc
);

    rob_pkg::commit_state_t state;
    rob_pkg::nick_t         head_ptr;
    logic                   mispredict;

    assign head_nick  = head_ptr;
    assign flush_all  = (state == rob_pkg::flush);
    // nothing retires while the buffer is being cleared
    assign retire     = (state == rob_pkg::run) && occupied && head_done;
    assign mispredict = !head_store && (head_taken != head_pred);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= rob_pkg::run;
            head_ptr <= '0;
        end else begin
            case (state)
                rob_pkg::run: begin
                    if (retire) begin
                        head_ptr <= head_ptr + 1'b1;
                        if (mispredict) begin
                            state <= rob_pkg::flush;
                        end
                    end
                end
                default: begin
                    head_ptr <= '0;
                    state    <= rob_pkg::run;
                end
            endcase
        end
    end

    // registered commit strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rf_en    <= 1'b0;
            store_en <= 1'b0;
            flush    <= 1'b0;
        end else begin
            rf_en    <= retire && !head_store;
            store_en <= retire && head_store;
            flush    <= retire && mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            rf_regnm    <= head_regnm;
            rf_data     <= head_data;
            rf_nick     <= head_ptr;
            store_nick  <= head_ptr;
            redirect_pc <= head_target;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_top (
    input  logic            clk,
    input  logic            arst_n,

    // allocation at rename
    input  logic            alloc_en,
    input  rob_pkg::regnm_t alloc_regnm,
    input  logic            alloc_store,
    input  logic            alloc_pred,
    output logic            full,
    output logic            nick_valid,
    output rob_pkg::nick_t  nick,

    // execute completion
    input  logic            ex_en,
    input  rob_pkg::nick_t  ex_nick,
    input  rob_pkg::data_t  ex_data,
    input  logic            ex_taken,
    input  rob_pkg::addr_t  ex_target,

    // store/load buffer completion
    input  logic            slb_en,
    input  rob_pkg::nick_t  slb_nick,
    input  rob_pkg::data_t  slb_data,

    // commit
    output logic            rf_en,
    output rob_pkg::regnm_t rf_regnm,
    output rob_pkg::data_t  rf_data,
    output rob_pkg::nick_t  rf_nick,
    output logic            store_en,
    output rob_pkg::nick_t  store_nick,
    output logic            flush,
    output rob_pkg::addr_t  redirect_pc
);

    rob_pkg::nick_t  head_nick;
    rob_pkg::regnm_t head_regnm;
    logic            head_store;
    logic            head_pred;
    logic            head_done;
    rob_pkg::data_t  head_data;
    logic            head_taken;
    rob_pkg::addr_t  head_target;
    logic            occupied;
    logic            retire;
    logic            flush_all;

    rob_alloc i_rob_alloc (
        .clk         (clk),
        .arst_n      (arst_n),
        .alloc_en    (alloc_en),
        .alloc_store (alloc_store),
        .alloc_pred  (alloc_pred),
        .alloc_regnm (alloc_regnm),
        .retire      (retire),
        .flush_all   (flush_all),
        .head_nick   (head_nick),
        .full        (full),
        .nick_valid  (nick_valid),
        .nick        (nick),
        .occupied    (occupied),
        .head_regnm  (head_regnm),
        .head_store  (head_store),
        .head_pred   (head_pred)
    );

    rob_result i_rob_result (
        .clk         (clk),
        .arst_n      (arst_n),
        .ex_en       (ex_en),
        .ex_nick     (ex_nick),
        .ex_data     (ex_data),
        .ex_taken    (ex_taken),
        .ex_target   (ex_target),
        .slb_en      (slb_en),
        .slb_nick    (slb_nick),
        .slb_data    (slb_data),
        .retire      (retire),
        .flush_all   (flush_all),
        .head_nick   (head_nick),
        .head_done   (head_done),
        .head_data   (head_data),
        .head_taken  (head_taken),
        .head_target (head_target)
    );

    rob_commit i_rob_commit (
        .clk         (clk),
        .arst_n      (arst_n),
        .head_regnm  (head_regnm),
        .head_store  (head_store),
        .head_pred   (head_pred),
        .head_done   (head_done),
        .head_taken  (head_taken),
        .head_data   (head_data),
        .head_target (head_target),
        .occupied    (occupied),
        .head_nick   (head_nick),
        .retire      (retire),
        .flush_all   (flush_all),
        .rf_en       (rf_en),
        .rf_regnm    (rf_regnm),
        .rf_data     (rf_data),
        .rf_nick     (rf_nick),
        .store_en    (store_en),
        .store_nick  (store_nick),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

endmodule

`default_nettype wire

// File: tests/tb_rob.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rob;

    logic            clk = 1'b0;
    logic            arst_n;
    logic            alloc_en, alloc_store, alloc_pred;
    rob_pkg::regnm_t alloc_regnm;
    logic            ex_en, ex_taken, slb_en;
    rob_pkg::nick_t  ex_nick, slb_nick;
    rob_pkg::data_t  ex_data, slb_data;
    rob_pkg::addr_t  ex_target;

    logic            full, nick_valid, rf_en, store_en, flush;
    rob_pkg::nick_t  nick, rf_nick, store_nick;
    rob_pkg::regnm_t rf_regnm;
    rob_pkg::data_t  rf_data;
    rob_pkg::addr_t  redirect_pc;

    logic [15:0]     lfsr;
    rob_pkg::nick_t  exp_nick;
    int              n_checks;
    int              n_errors;

    // entries allocated by fill, oldest at index 0
    rob_pkg::nick_t  q_nick [16];
    rob_pkg::regnm_t q_reg  [16];
    rob_pkg::data_t  q_data [16];
    logic            q_pred [16];

    rob_top i_rob_top (.*);

    always #2 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    function automatic rob_pkg::regnm_t rand_reg();
        return rob_pkg::regnm_t'(rand_bits(5));
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic allocate(input rob_pkg::regnm_t r, input logic st, input logic pr,
                            input logic exp_valid, output rob_pkg::nick_t got);
        alloc_en    = 1'b1;
        alloc_regnm = r;
        alloc_store = st;
        alloc_pred  = pr;
        @(negedge clk);
        got = exp_nick;
        check("nick_valid", nick_valid, exp_valid);
        check("nick", nick, exp_nick);
        if (exp_valid) begin
            exp_nick = exp_nick + 1'b1;
        end
        next_cycle();
        alloc_en = 1'b0;
    endtask

    task automatic complete_ex(input rob_pkg::nick_t n, input rob_pkg::data_t d,
                               input logic tk, input rob_pkg::addr_t tg);
        ex_en     = 1'b1;
        ex_nick   = n;
        ex_data   = d;
        ex_taken  = tk;
        ex_target = tg;
        next_cycle();
        ex_en = 1'b0;
    endtask

    task automatic expect_commit(input logic st, input rob_pkg::nick_t n,
                                 input rob_pkg::regnm_t r, input rob_pkg::data_t d,
                                 input logic fl, input rob_pkg::addr_t pc);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!(rf_en || store_en) && cycles < 20);
        if (!(rf_en || store_en)) begin
            n_errors++;
            $display("Timeout: no commit output within %0d cycles at %0t", cycles, $time);
        end else begin
            check("store_en", store_en, st);
            check("rf_en", rf_en, !st);
            check(st ? "store_nick" : "rf_nick", st ? store_nick : rf_nick, n);
            if (!st) begin
                check("rf_regnm", rf_regnm, r);
                check("rf_data", rf_data, d);
            end
            check("flush", flush, fl);
            if (fl) begin
                check("redirect_pc", redirect_pc, pc);
            end
        end
    endtask

    // non-stores with random register, data and prediction
    task automatic fill(input int count);
        for (int i = 0; i < count; i++) begin
            q_reg[i]  = rand_reg();
            q_pred[i] = 1'(rand_bits(1));
            q_data[i] = rand_bits(32);
            allocate(q_reg[i], 1'b0, q_pred[i], 1'b1, q_nick[i]);
        end
    endtask

    // youngest first, so nothing commits before the oldest completes
    task automatic complete_reverse(input int first, input int last);
        for (int i = last; i >= first; i--) begin
            complete_ex(q_nick[i], q_data[i], q_pred[i], '0);
        end
    endtask

    task automatic expect_in_order(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            expect_commit(1'b0, q_nick[i], q_reg[i], q_data[i], 1'b0, '0);
        end
    endtask

    task automatic reset_state();
        check("full", full, 1'b0);
        check("rf_en", rf_en, 1'b0);
        check("store_en", store_en, 1'b0);
        check("flush", flush, 1'b0);
        fill(1);
        complete_reverse(0, 0);
        expect_in_order(0, 0);
        next_cycle();
    endtask

    task automatic out_of_order();
        fill(4);
        complete_reverse(0, 3);
        expect_in_order(0, 3);
        next_cycle();
    endtask

    task automatic full_buffer();
        rob_pkg::nick_t n;
        fill(16);
        check("full", full, 1'b1);
        allocate(rand_reg(), 1'b0, 1'b0, 1'b0, n);
        complete_reverse(0, 0);
        expect_in_order(0, 0);
        check("full", full, 1'b0);
        next_cycle();
        complete_reverse(1, 15);
        expect_in_order(1, 15);
        next_cycle();
    endtask

    task automatic store_release();
        rob_pkg::nick_t ns;
        allocate(rand_reg(), 1'b1, 1'b0, 1'b1, ns);
        fill(1);
        slb_en   = 1'b1;
        slb_nick = ns;
        slb_data = rand_bits(32);
        complete_ex(q_nick[0], q_data[0], q_pred[0], '0);
        slb_en = 1'b0;
        expect_commit(1'b1, ns, '0, '0, 1'b0, '0);
        expect_in_order(0, 0);
        next_cycle();
    endtask

    task automatic mispredict_flush();
        rob_pkg::nick_t  nb;
        rob_pkg::regnm_t rb;
        rob_pkg::data_t  db;
        rob_pkg::addr_t  tg;
        rb = rand_reg();
        db = rand_bits(32);
        tg = rand_bits(32);
        allocate(rb, 1'b0, 1'b0, 1'b1, nb);
        fill(2);
        complete_reverse(0, 1);
        complete_ex(nb, db, 1'b1, tg);
        expect_commit(1'b0, nb, rb, db, 1'b1, tg);
        // younger entries are dropped by the flush
        repeat (6) begin
            @(negedge clk);
            check("rf_en", rf_en, 1'b0);
        end
        next_cycle();
        exp_nick = '0;
        check("full", full, 1'b0);
        allocate(rand_reg(), 1'b0, 1'b0, 1'b1, nb);
    endtask

    initial begin
        lfsr        = 16'd13;
        exp_nick    = '0;
        n_checks    = 0;
        n_errors    = 0;
        arst_n      = 1'b0;
        alloc_en    = 1'b0;
        alloc_regnm = '0;
        alloc_store = 1'b0;
        alloc_pred  = 1'b0;
        ex_en       = 1'b0;
        ex_nick     = '0;
        ex_data     = '0;
        ex_taken    = 1'b0;
        ex_target   = '0;
        slb_en      = 1'b0;
        slb_nick    = '0;
        slb_data    = '0;
        repeat (3) @(posedge clk);
        #0.5;
        arst_n = 1'b1;
        reset_state();
        out_of_order();
        full_buffer();
        store_release();
        mispredict_flush();
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rob_top.f
hdl/rob_pkg.sv
hdl/rob_alloc.sv
hdl/rob_result.sv
hdl/rob_commit.sv
hdl/rob_top.sv
tests/tb_rob.sv

// File: Makefile
# Verilator build and run of the reorder buffer testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_rob and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -Wno-fatal -f rob_top.f --top-module tb_rob \
		--Mdir obj_dir -o tb_rob
	./obj_dir/tb_rob | tee $(LOG)
	@if grep -qx "Everything OK" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
